// File: all.f
+incdir+.
icap_bridge_pkg.sv
icap_word_fifo.sv
icap_open_reset.sv
icap_loader.sv
phy_reset_gen.sv
icap_bridge_top.sv
tb_icap_bridge.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_icap_bridge

# the run result is judged by its output, not its exit status
out=$(./obj_dir/Vtb_icap_bridge 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: tb_icap_bridge.sv
`timescale 1ns/10ps

`include "icap_bridge_config.svh"

module tb_icap_bridge;
	import icap_bridge_pkg::*;

	localparam int DLY = `RST_DELAY_LEN;
	localparam int DEPTH = `ICAP_FIFO_DEPTH;
	// quiesce stays high long enough to fill the reset stretch line
	localparam int QUIESCE_HOLD = `RST_DELAY_LEN + 16;
	// the whole sequence needs a few hundred cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic pcie_clk;
	logic icap_reset_delay;
	icap_wr_s host_wr;
	logic host_open;
	logic quiesce;
	logic host_full;
	icap_port_s icap_port;
	logic icap_busy;
	logic phy_rst;

	// words taken by the buffer and not yet seen on the port
	icap_word_t exp_q[$];
	icap_word_t want_word;
	logic [31:0] lcg_state;
	// set while a strobe on the port is legal
	logic drain_allowed;
	int cycle_cnt;

	icap_bridge_top u_icap_bridge_top (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.host_wr_i(host_wr),
		.host_open_i(host_open),
		.quiesce_i(quiesce),
		.host_full_o(host_full),
		.icap_o(icap_port),
		.icap_busy_o(icap_busy),
		.phy_rst_o(phy_rst)
	);

	////////////////////
	// clock and timeout
	////////////////////

	initial begin
		pcie_clk = 1'b0;
		forever #5 pcie_clk = ~pcie_clk;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge pcie_clk);
			cycle_cnt++;
		end
		stop_on_error("timeout, the test sequence did not finish in time");
	end

	////////////////////
	// helpers
	////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			stop_on_error($sformatf("** Error: %s got 0x%0h expected 0x%0h",
				name, got, want));
		end
	endtask

	// numerical recipes constants
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// reference model where words leave in the order they were taken
	function automatic icap_word_t expected_word();
		return exp_q.pop_front();
	endfunction

	////////////////////
	// port checker
	////////////////////

	// outputs only move on the rising edge, so the falling edge is quiet
	always @(negedge pcie_clk) begin
		if (!icap_reset_delay) begin
			check_value("icap_o.write_n", 32'(icap_port.write_n), 32'(icap_port.ce_n));
			if (!icap_port.ce_n) begin
				if (!drain_allowed) begin
					stop_on_error("configuration strobe while quiesce is low");
				end else if (exp_q.size() == 0) begin
					stop_on_error("configuration strobe with no word outstanding");
				end else begin
					want_word = expected_word();
					check_value("icap_o.data", 32'(icap_port.data), 32'(want_word));
				end
			end
		end
	end

	////////////////////
	// stimulus tasks
	////////////////////

	// idle outputs after reset and the reset stretch on phy_rst_o
	task automatic check_reset_state();
		int n;
		@(negedge pcie_clk);
		n = 0;
		check_value("icap_o.ce_n", 32'(icap_port.ce_n), 32'd1);
		check_value("icap_o.write_n", 32'(icap_port.write_n), 32'd1);
		check_value("icap_busy_o", 32'(icap_busy), 32'd0);
		check_value("phy_rst_o", 32'(phy_rst), 32'd1);
		while (phy_rst && n < 4 * DLY) begin
			@(negedge pcie_clk);
			n++;
		end
		check_value("phy_rst_o release cycles", 32'(n), 32'(DLY + 1));
	endtask

	// one write attempt per cycle with quiesce low and no flush running
	task automatic write_words(input int count);
		int i;
		icap_word_t w;
		for (i = 0; i < count; i++) begin
			@(posedge pcie_clk);
			#1;
			lcg_state = lcg_next(lcg_state);
			w = lcg_state[31:16];
			host_wr.data = w;
			host_wr.en = 1'b1;
			@(negedge pcie_clk);
			// full exactly when the buffer holds DEPTH words
			check_value("host_full_o", 32'(host_full), 32'(exp_q.size() >= DEPTH));
			if (!host_full) begin
				exp_q.push_back(w);
			end
		end
		@(posedge pcie_clk);
		#1 host_wr.en = 1'b0;
	endtask

	// raise quiesce and hold it until every word is out
	task automatic drain_words();
		int held;
		@(posedge pcie_clk);
		#1;
		quiesce = 1'b1;
		drain_allowed = 1'b1;
		held = 0;
		while (held < QUIESCE_HOLD || exp_q.size() != 0) begin
			@(negedge pcie_clk);
			held++;
			// two sync stages plus the reset flop
			if (held > 3) begin
				check_value("phy_rst_o", 32'(phy_rst), 32'd1);
			end
		end
	endtask

	// phy_rst_o follows a quiesce fall three edges later
	task automatic drop_quiesce();
		int n;
		@(posedge pcie_clk);
		#1 quiesce = 1'b0;
		@(negedge pcie_clk);
		n = 0;
		while (phy_rst && n < 4 * DLY) begin
			@(negedge pcie_clk);
			n++;
		end
		check_value("phy_rst_o fall cycles", 32'(n), 32'd3);
		// let the read request settle before strobes become illegal
		repeat (2) @(negedge pcie_clk);
		drain_allowed = 1'b0;
	endtask

	// opening the stream throws buffered words away
	task automatic open_stream();
		int n;
		@(posedge pcie_clk);
		#1 host_open = 1'b1;
		exp_q.delete();
		// the open level is taken on the next edge
		repeat (2) @(negedge pcie_clk);
		check_value("host_full_o", 32'(host_full), 32'd1);
		n = 0;
		while (host_full && n < 4 * DLY) begin
			n++;
			@(negedge pcie_clk);
		end
		if (n < DLY || n > DLY + 1) begin
			stop_on_error($sformatf("flush held host_full_o for %0d cycles, not %0d or %0d",
				n, DLY, DLY + 1));
		end
		check_value("icap_busy_o", 32'(icap_busy), 32'd0);
		@(posedge pcie_clk);
		#1 host_open = 1'b0;
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		icap_reset_delay = 1'b1;
		host_wr = '0;
		host_open = 1'b0;
		quiesce = 1'b0;
		drain_allowed = 1'b0;
		lcg_state = 32'hfb17_fb15;
		want_word = '0;
		repeat (2) @(posedge pcie_clk);
		#1 icap_reset_delay = 1'b0;

		// idle state and first reset stretch
		check_reset_state();

		// extra words past the depth bounce off full
		write_words(DEPTH + 4);
		@(negedge pcie_clk);
		check_value("icap_busy_o", 32'(icap_busy), 32'd1);

		// drain in order, then the bridge reset follows quiesce down
		drain_words();
		drop_quiesce();

		// words caught by an open never reach the port
		write_words(8);
		open_stream();
		write_words(6);
		@(negedge pcie_clk);
		check_value("icap_busy_o", 32'(icap_busy), 32'd1);
		drain_words();
		drop_quiesce();

		$display("No errors");
		$finish;
	end

endmodule

// File: icap_bridge_top.sv
`timescale 1ns/10ps

module icap_bridge_top (
	input logic pcie_clk,
	input logic icap_reset_delay,
	input icap_bridge_pkg::icap_wr_s host_wr_i,
	input logic host_open_i,
	input logic quiesce_i,
	output logic host_full_o,
	output icap_bridge_pkg::icap_port_s icap_o,
	output logic icap_busy_o,
	output logic phy_rst_o
);
	// buffer flush while the stream is being opened
	logic flush;
	// one cycle marker of a new open
	logic open_pulse;

	////////////////////
	// open handling
	////////////////////

	icap_open_reset u_icap_open_reset (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.open_i(host_open_i),
		.flush_o(flush),
		.open_pulse_o(open_pulse)
	);

	////////////////////
	// config path
	////////////////////

	icap_loader u_icap_loader (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.wr_i(host_wr_i),
		.full_o(host_full_o),
		.flush_i(flush),
		.open_pulse_i(open_pulse),
		.quiesce_i(quiesce_i),
		.icap_o(icap_o),
		.busy_o(icap_busy_o)
	);

	////////////////////
	// bridge reset
	////////////////////

	// shares only quiesce with the config path
	phy_reset_gen u_phy_reset_gen (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.quiesce_i(quiesce_i),
		.phy_rst_o(phy_rst_o)
	);

endmodule

// File: phy_reset_gen.sv
`timescale 1ns/10ps

`include "icap_bridge_config.svh"

module phy_reset_gen (
	input logic pcie_clk,
	input logic icap_reset_delay,
	input logic quiesce_i,
	output logic phy_rst_o
);
	localparam int DLY = `RST_DELAY_LEN;

	// two flop quiesce synchronizer
	logic [1:0] quiesce_sync;
	// history of the reset output
	logic [DLY-1:0] rst_line;
	logic rst_next;

	////////////////////
	// stretch rule
	////////////////////

	// quiesce forces reset
	// otherwise reset holds until its own delayed copy comes back high
	assign rst_next = quiesce_sync[1] || (phy_rst_o && !rst_line[DLY-1]);

	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay) begin
			quiesce_sync <= 2'b00;
			rst_line <= '0;
			// bridge comes up held in reset
			phy_rst_o <= 1'b1;
		end else begin
			quiesce_sync <= {quiesce_sync[0], quiesce_i};
			rst_line <= {rst_line[DLY-2:0], phy_rst_o};
			phy_rst_o <= rst_next;
		end
	end

	// a pulse started from a clear history lasts at least DLY cycles
	// after DLY cycles every stage must have seen it
	a_min_pulse: assert property (@(posedge pcie_clk)
		disable iff (icap_reset_delay)
		($rose(phy_rst_o) && (rst_line == '0)) |-> ##DLY (&rst_line));

endmodule

// File: icap_loader.sv
`timescale 1ns/10ps

`include "icap_bridge_config.svh"

module icap_loader (
	input logic pcie_clk,
	input logic icap_reset_delay,
	input icap_bridge_pkg::icap_wr_s wr_i,
	output logic full_o,
	input logic flush_i,
	input logic open_pulse_i,
	input logic quiesce_i,
	output icap_bridge_pkg::icap_port_s icap_o,
	output logic busy_o
);
	import icap_bridge_pkg::*;

	// head word from the buffer
	icap_word_t fifo_dat;
	logic fifo_full;
	logic fifo_valid;
	logic fifo_empty;

	// quiesce synchronizer where bit 1 is the usable copy
	logic [1:0] quiesce_sync;
	// registered read request
	logic rd_req;
	// word actually leaving the buffer this cycle
	logic rd_eff;

	////////////////////
	// word buffer
	////////////////////

	icap_word_fifo u_icap_word_fifo (
		.pcie_clk(pcie_clk),
		.icap_reset_delay(icap_reset_delay),
		.flush_i(flush_i),
		.wr_i(wr_i),
		.full_o(fifo_full),
		.rd_i(rd_eff),
		.dat_o(fifo_dat),
		.valid_o(fifo_valid),
		.empty_o(fifo_empty)
	);

	// host sees full during the whole flush as well
	assign full_o = fifo_full || flush_i;

	////////////////////
	// drain control
	////////////////////

	// request is a cycle late so it has to be qualified by valid again
	assign rd_eff = rd_req && fifo_valid;

	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay) begin
			quiesce_sync <= 2'b00;
			rd_req <= 1'b0;
			busy_o <= 1'b0;
		end else begin
			quiesce_sync <= {quiesce_sync[0], quiesce_i};
			// only drain while the host is quiet
			rd_req <= fifo_valid && !fifo_empty && quiesce_sync[1];
			// busy holds until the next open and the clear beats the set
			if (open_pulse_i) busy_o <= 1'b0;
			else if (!fifo_empty) busy_o <= 1'b1;
		end
	end

	// config port strobes are the inverted read
	always_comb begin
		icap_o.ce_n = ~rd_eff;
		icap_o.write_n = ~rd_eff;
		icap_o.data = fifo_dat;
	end

	// no strobe while the synced quiesce is low
	a_ce_needs_quiesce: assert property (@(posedge pcie_clk)
		disable iff (icap_reset_delay)
		!icap_o.ce_n |-> quiesce_sync[1]);

endmodule

// File: icap_open_reset.sv
`timescale 1ns/10ps

`include "icap_bridge_config.svh"

module icap_open_reset (
	input logic pcie_clk,
	input logic icap_reset_delay,
	input logic open_i,
	output logic flush_o,
	output logic open_pulse_o
);
	localparam int DLY = `RST_DELAY_LEN;
	localparam int FLUSH_MAX = `RST_DELAY_LEN + 1;

	// registered open level
	logic open_q;
	// open level shifted down the delay line
	logic [DLY-1:0] open_line;
	logic open_delay;
	logic open_rise;

	// open goes high, the stream was just opened by the host
	assign open_rise = open_i && !open_q;
	// end of the delay line, stops the flush
	assign open_delay = open_line[DLY-1];

	////////////////////
	// flush timing
	////////////////////

	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay) begin
			open_q <= 1'b0;
			open_line <= '0;
			flush_o <= 1'b0;
			open_pulse_o <= 1'b0;
		end else begin
			open_q <= open_i;
			open_line <= {open_line[DLY-2:0], open_q};
			// single cycle, lines up with the first flush cycle
			open_pulse_o <= open_rise;
			// end of the delay line wins over a new open
			if (open_delay) flush_o <= 1'b0;
			else if (open_rise) flush_o <= 1'b1;
		end
	end

	// the open level always reaches the end of the line
	// so a flush cannot hang
	a_flush_bounded: assert property (@(posedge pcie_clk)
		disable iff (icap_reset_delay)
		$rose(flush_o) |-> ##FLUSH_MAX !flush_o);

endmodule

// File: icap_word_fifo.sv
`timescale 1ns/10ps

`include "icap_bridge_config.svh"

module icap_word_fifo (
	input logic pcie_clk,
	input logic icap_reset_delay,
	input logic flush_i,
	input icap_bridge_pkg::icap_wr_s wr_i,
	output logic full_o,
	input logic rd_i,
	output icap_bridge_pkg::icap_word_t dat_o,
	output logic valid_o,
	output logic empty_o
);
	import icap_bridge_pkg::*;

	localparam int DEPTH = `ICAP_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);
	localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

	// word storage
	icap_word_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	// stored word count needs one bit more than the pointers
	logic [AW:0] count;
	logic wr_ok;
	logic rd_ok;

	////////////////////
	// status
	////////////////////

	assign full_o = (count == FULL_CNT);

	// head word shows up without a read in fwft style
	// flushing hides whatever is still stored
	assign valid_o = (count != '0) && !flush_i;
	assign empty_o = !valid_o;
	assign dat_o = mem[rd_ptr];

	// writes are dropped while full or flushing
	assign wr_ok = wr_i.en && !full_o && !flush_i;
	assign rd_ok = rd_i && valid_o;

	////////////////////
	// pointers
	////////////////////

	always_ff @(posedge pcie_clk) begin
		if (icap_reset_delay || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap on their own since the depth is a power of two
			if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage write
	always_ff @(posedge pcie_clk) begin
		if (wr_ok) mem[wr_ptr] <= wr_i.data;
	end

	////////////////////
	// checks
	////////////////////

	// a write against a full buffer must leave the unread head word alone
	a_no_wr_when_full: assert property (@(posedge pcie_clk)
		disable iff (icap_reset_delay || flush_i)
		(wr_i.en && full_o && !rd_i) |=> (full_o && $stable(dat_o)));

	// the loader only reads a word that is there
	a_no_rd_when_empty: assert property (@(posedge pcie_clk)
		disable iff (icap_reset_delay)
		rd_i |-> !empty_o);

endmodule

// File: icap_bridge_pkg.sv
`include "icap_bridge_config.svh"

package icap_bridge_pkg;

	////////////////////
	// payload types
	////////////////////

	// one configuration word, held as the host bytes that make it up
	// byte 0 is the low byte
	typedef logic [`ICAP_WORD_W/`PKT_BYTE_W-1:0][`PKT_BYTE_W-1:0] icap_word_t;

	// host write strobe
	// the word is taken when en is high and the buffer reports not full
	typedef struct packed {
		icap_word_t data;
		logic en;
	} icap_wr_s;

	////////////////////
	// config port
	////////////////////

	// both strobes are active low
	// a word is written on a cycle where ce_n and write_n are both low
	typedef struct packed {
		logic ce_n;
		logic write_n;
		icap_word_t data;
	} icap_port_s;

endpackage

// File: icap_bridge_config.svh
`ifndef ICAP_BRIDGE_CONFIG_SVH
`define ICAP_BRIDGE_CONFIG_SVH

////////////////////
// widths
////////////////////

// configuration port word width
`define ICAP_WORD_W 16
// host stream byte width, a config word is built from whole bytes
`define PKT_BYTE_W 8

////////////////////
// depths and delays
////////////////////

// stages in the open delay line and in the reset stretch line
`define RST_DELAY_LEN 32
// entries in the configuration word buffer
`define ICAP_FIFO_DEPTH 16

`endif
